//--- hw/ddr_consts.svh
`default_nettype none
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

`define DDR_NUM_SLOTS    4                          // slots, also host credits
`define DDR_SLOT_W       $clog2(`DDR_NUM_SLOTS)     // slot index width
`define DDR_BG_NUM       4                          // bank groups
`define DDR_BANKS_PER_BG 4
`define DDR_BANKS        (`DDR_BG_NUM * `DDR_BANKS_PER_BG) // 16 banks total

// flat host address layout
`define DDR_COL_LSB      0
`define DDR_COL_MSB      9
`define DDR_BANK_LSB     10
`define DDR_BANK_MSB     11
`define DDR_BG_LSB       12
`define DDR_BG_MSB       13
`define DDR_ROW_LSB      14
`define DDR_ROW_MSB      29

// timing, clocks between command issues
`define DDR_T_RCD        6   // act to rd/wr
`define DDR_T_RP         6   // pre to act
`define DDR_T_RC         20  // act to act, same bank
`define DDR_T_RAS        14  // act to pre
`define DDR_T_RTP        3   // rd to pre
`define DDR_T_WTP        6   // wr to pre
`define DDR_T_RRD        3   // act to act, same group
`define DDR_T_CCD        8   // col to col incl burst
`define DDR_T_RTW        19  // rd to wr turnaround
`define DDR_T_WTR        21  // wr to rd turnaround

`endif
`default_nettype wire

//--- hw/ddr_cmd_pkg.sv
`default_nettype none

package ddr_cmd_pkg;

	// command driven toward the dram
	typedef enum logic [2:0] {
		none,       // idle cycle
		activate,   // open a row
		precharge,  // close the open row
		read_cmd,
		write_cmd
	} dram_cmd_t;

	typedef enum logic {
		rd,
		wr
	} acc_type_t;  // host access kind

	typedef enum logic {
		empty,   // free for intake
		queued   // waiting for issue
	} slot_state_t;

endpackage

`default_nettype wire

//--- hw/ddr_addr_pkg.sv
`include "ddr_consts.svh"
`default_nettype none

package ddr_addr_pkg;

	// field widths follow the address layout
	typedef logic [`DDR_BG_MSB-`DDR_BG_LSB:0]     bg_t;
	typedef logic [`DDR_BANK_MSB-`DDR_BANK_LSB:0] bank_t;
	typedef logic [`DDR_ROW_MSB-`DDR_ROW_LSB:0]   row_t;
	typedef logic [`DDR_COL_MSB-`DDR_COL_LSB:0]   col_t;

	// {bg, bank}, indexes the per-bank tables
	typedef logic [$clog2(`DDR_BANKS)-1:0] bank_id_t;

endpackage

`default_nettype wire

//--- hw/req_intake.sv
`timescale 1ns/1ps
`include "ddr_consts.svh"
`default_nettype none

module req_intake
	import ddr_cmd_pkg::*, ddr_addr_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,       // sync, high = reset

	// host side, one cycle per request
	input  logic        req_valid,
	input  acc_type_t   req_type,
	input  logic [31:0] req_addr,

	// slot write port
	output logic        slot_wr,
	output acc_type_t   wr_type,
	output bg_t         wr_bg,
	output bank_t       wr_bank,
	output row_t        wr_row,
	output col_t        wr_col
);

	bg_t   dec_bg;    // decoded fields
	bank_t dec_bank;
	row_t  dec_row;
	col_t  dec_col;

	// address slicing per header layout
	always_comb begin
		dec_col  = req_addr[`DDR_COL_MSB:`DDR_COL_LSB];
		dec_bank = req_addr[`DDR_BANK_MSB:`DDR_BANK_LSB];
		dec_bg   = req_addr[`DDR_BG_MSB:`DDR_BG_LSB];
		dec_row  = req_addr[`DDR_ROW_MSB:`DDR_ROW_LSB];
	end

	// write strobe, one cycle behind the host
	always_ff @(posedge clk) begin
		if (rst_n) begin
			slot_wr <= 1'b0;
		end else begin
			slot_wr <= req_valid;
		end
	end

	// decoded payload, loaded only on a request
	always_ff @(posedge clk) begin
		if (req_valid) begin
			wr_type <= req_type;
			wr_bg   <= dec_bg;
			wr_bank <= dec_bank;
			wr_row  <= dec_row;
			wr_col  <= dec_col;   // upper addr bits ignored
		end
	end

endmodule

`default_nettype wire

//--- hw/req_slots.sv
`timescale 1ns/1ps
`include "ddr_consts.svh"
`default_nettype none

module req_slots
	import ddr_cmd_pkg::*, ddr_addr_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,  // sync, high = reset

	// write from intake
	input  logic                            slot_wr,
	input  acc_type_t                       wr_type,
	input  bg_t                             wr_bg,
	input  bank_t                           wr_bank,
	input  row_t                            wr_row,
	input  col_t                            wr_col,

	// issue from controller
	input  logic                            issue_valid,
	input  logic [`DDR_SLOT_W-1:0]          issue_slot,

	// slot contents toward controller
	output slot_state_t [`DDR_NUM_SLOTS-1:0] slot_state,
	output acc_type_t   [`DDR_NUM_SLOTS-1:0] slot_type,
	output bg_t         [`DDR_NUM_SLOTS-1:0] slot_bg,
	output bank_t       [`DDR_NUM_SLOTS-1:0] slot_bank,
	output row_t        [`DDR_NUM_SLOTS-1:0] slot_row,
	output col_t                            slot_col_of_issue,

	output logic                            credit_return  // one pulse per freed slot
);

	col_t [`DDR_NUM_SLOTS-1:0] slot_col;     // columns stay here
	logic [`DDR_SLOT_W-1:0]    free_idx;     // lowest empty slot

	// lowest empty slot, scan from the top so index 0 wins
	always_comb begin
		free_idx = '0;
		for (int i = `DDR_NUM_SLOTS - 1; i >= 0; i--) begin
			if (slot_state[i] == empty) begin
				free_idx = `DDR_SLOT_W'(i);
			end
		end
	end

	// column of the slot being issued, same cycle as the grant
	assign slot_col_of_issue = slot_col[issue_slot];

	// slot state and credit pulse
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < `DDR_NUM_SLOTS; i++) begin
				slot_state[i] <= empty;
			end
			credit_return <= 1'b0;
		end else begin
			// credits guarantee a free slot on every write
			if (slot_wr) begin
				slot_state[free_idx] <= queued;
			end
			// issued slot is still queued here, so never equal to free_idx
			if (issue_valid) begin
				slot_state[issue_slot] <= empty;
			end
			credit_return <= issue_valid;  // lines up with the rd/wr on cmd
		end
	end

	// payload, only meaningful while queued
	always_ff @(posedge clk) begin
		if (slot_wr) begin
			slot_type[free_idx] <= wr_type;
			slot_bg[free_idx]   <= wr_bg;
			slot_bank[free_idx] <= wr_bank;
			slot_row[free_idx]  <= wr_row;
			slot_col[free_idx]  <= wr_col;
		end
	end

endmodule

`default_nettype wire

//--- hw/timing_controller.sv
`timescale 1ns/1ps
`include "ddr_consts.svh"
`default_nettype none

module timing_controller
	import ddr_cmd_pkg::*, ddr_addr_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,  // sync, high = reset

	// slot contents
	input  slot_state_t [`DDR_NUM_SLOTS-1:0] slot_state,
	input  acc_type_t   [`DDR_NUM_SLOTS-1:0] slot_type,
	input  bg_t         [`DDR_NUM_SLOTS-1:0] slot_bg,
	input  bank_t       [`DDR_NUM_SLOTS-1:0] slot_bank,
	input  row_t        [`DDR_NUM_SLOTS-1:0] slot_row,
	input  col_t                            slot_col_of_issue,

	// grant of a rd/wr back to the slots
	output logic                            issue_valid,
	output logic [`DDR_SLOT_W-1:0]          issue_slot,

	// registered command
	output dram_cmd_t                       cmd,
	output bg_t                             cmd_bg,
	output bank_t                           cmd_bank,
	output row_t                            cmd_row,
	output col_t                            cmd_col   // rd/wr only
);

	// a counter at value v means the command went out v+1 issue slots ago,
	// so a gap of T needs v >= T-1; each saturates at its largest limit
	localparam int ACT_SAT = `DDR_T_RC - 1;   // RC covers RAS and RCD too
	localparam int RD_SAT  = `DDR_T_RTP - 1;
	localparam int WR_SAT  = `DDR_T_WTP - 1;
	localparam int PRE_SAT = `DDR_T_RP - 1;
	localparam int RRD_SAT = `DDR_T_RRD - 1;
	localparam int GRD_SAT = (`DDR_T_RTW > `DDR_T_CCD) ? `DDR_T_RTW - 1 : `DDR_T_CCD - 1;
	localparam int GWR_SAT = (`DDR_T_WTR > `DDR_T_CCD) ? `DDR_T_WTR - 1 : `DDR_T_CCD - 1;
	localparam int ACT_W   = $clog2(ACT_SAT + 1);
	localparam int RD_W    = $clog2(RD_SAT + 1);
	localparam int WR_W    = $clog2(WR_SAT + 1);
	localparam int PRE_W   = $clog2(PRE_SAT + 1);
	localparam int RRD_W   = $clog2(RRD_SAT + 1);
	localparam int GRD_W   = $clog2(GRD_SAT + 1);
	localparam int GWR_W   = $clog2(GWR_SAT + 1);

	row_t [`DDR_BANKS-1:0]             open_row;   // row per bank
	logic [`DDR_BANKS-1:0]             row_open;   // bank has a row
	logic [`DDR_BANKS-1:0][ACT_W-1:0]  act_cnt;
	logic [`DDR_BANKS-1:0][RD_W-1:0]   rd_cnt;
	logic [`DDR_BANKS-1:0][WR_W-1:0]   wr_cnt;
	logic [`DDR_BANKS-1:0][PRE_W-1:0]  pre_cnt;
	logic [`DDR_BG_NUM-1:0][RRD_W-1:0] bg_act_cnt;
	logic [GRD_W-1:0]                  g_rd_cnt;   // since last read, any bank
	logic [GWR_W-1:0]                  g_wr_cnt;   // since last write, any bank
	acc_type_t                         last_col;   // type of last column cmd
	logic [`DDR_SLOT_W-1:0]            rr_ptr;     // search start

	dram_cmd_t [`DDR_NUM_SLOTS-1:0]    need_cmd;   // next cmd per slot
	logic [`DDR_NUM_SLOTS-1:0]         elig;       // need_cmd allowed now
	logic                              rd_ok;      // turnaround ok for rd
	logic                              wr_ok;
	logic                              sel_valid;
	logic [`DDR_SLOT_W-1:0]            sel_slot;
	dram_cmd_t                         sel_cmd;
	bank_id_t                          sel_bid;

	// bus turnaround and col-to-col, checked against the last column cmd only
	always_comb begin
		rd_ok = (last_col == rd) ? (g_rd_cnt >= GRD_W'(`DDR_T_CCD - 1))
		                         : (g_wr_cnt >= GWR_W'(`DDR_T_WTR - 1));
		wr_ok = (last_col == wr) ? (g_wr_cnt >= GWR_W'(`DDR_T_CCD - 1))
		                         : (g_rd_cnt >= GRD_W'(`DDR_T_RTW - 1));
	end

	// per-slot command and eligibility
	always_comb begin
		bank_id_t bid;
		for (int i = 0; i < `DDR_NUM_SLOTS; i++) begin
			bid         = {slot_bg[i], slot_bank[i]};
			need_cmd[i] = none;
			elig[i]     = 1'b0;
			if (slot_state[i] == queued) begin
				if (!row_open[bid]) begin  // bank closed
					need_cmd[i] = activate;
					elig[i] = (pre_cnt[bid] >= PRE_W'(`DDR_T_RP - 1)) &&
					          (act_cnt[bid] >= ACT_W'(`DDR_T_RC - 1)) &&
					          (bg_act_cnt[slot_bg[i]] >= RRD_W'(`DDR_T_RRD - 1));
				end else if (open_row[bid] != slot_row[i]) begin  // row conflict
					need_cmd[i] = precharge;
					elig[i] = (act_cnt[bid] >= ACT_W'(`DDR_T_RAS - 1)) &&
					          (rd_cnt[bid] >= RD_W'(`DDR_T_RTP - 1)) &&
					          (wr_cnt[bid] >= WR_W'(`DDR_T_WTP - 1));
				end else begin  // row hit
					need_cmd[i] = (slot_type[i] == rd) ? read_cmd : write_cmd;
					elig[i] = (act_cnt[bid] >= ACT_W'(`DDR_T_RCD - 1)) &&
					          ((slot_type[i] == rd) ? rd_ok : wr_ok);
				end
			end
		end
	end

	// round robin, first eligible slot from rr_ptr upward
	always_comb begin
		logic [`DDR_SLOT_W-1:0] idx;
		sel_valid = 1'b0;
		sel_slot  = rr_ptr;
		for (int k = 0; k < `DDR_NUM_SLOTS; k++) begin
			idx = rr_ptr + `DDR_SLOT_W'(k);  // wraps, slot count is a power of two
			if (!sel_valid && elig[idx]) begin
				sel_valid = 1'b1;
				sel_slot  = idx;
			end
		end
	end

	assign sel_cmd     = sel_valid ? need_cmd[sel_slot] : none;
	assign sel_bid     = {slot_bg[sel_slot], slot_bank[sel_slot]};
	assign issue_valid = (sel_cmd == read_cmd) || (sel_cmd == write_cmd);
	assign issue_slot  = sel_slot;

	// counters, row table, pointer and cmd
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int b = 0; b < `DDR_BANKS; b++) begin
				act_cnt[b] <= ACT_W'(ACT_SAT);  // saturated, every rule met
				rd_cnt[b]  <= RD_W'(RD_SAT);
				wr_cnt[b]  <= WR_W'(WR_SAT);
				pre_cnt[b] <= PRE_W'(PRE_SAT);
			end
			for (int g = 0; g < `DDR_BG_NUM; g++) begin
				bg_act_cnt[g] <= RRD_W'(RRD_SAT);
			end
			row_open <= '0;
			g_rd_cnt <= GRD_W'(GRD_SAT);
			g_wr_cnt <= GWR_W'(GWR_SAT);
			last_col <= rd;
			rr_ptr   <= '0;
			cmd      <= none;
		end else begin
			for (int b = 0; b < `DDR_BANKS; b++) begin
				if (sel_cmd == activate && sel_bid == b) begin
					act_cnt[b]  <= '0;
					row_open[b] <= 1'b1;
				end else if (act_cnt[b] != ACT_W'(ACT_SAT)) begin
					act_cnt[b] <= act_cnt[b] + 1'b1;
				end
				if (sel_cmd == precharge && sel_bid == b) begin
					pre_cnt[b]  <= '0;
					row_open[b] <= 1'b0;
				end else if (pre_cnt[b] != PRE_W'(PRE_SAT)) begin
					pre_cnt[b] <= pre_cnt[b] + 1'b1;
				end
				if (sel_cmd == read_cmd && sel_bid == b) begin
					rd_cnt[b] <= '0;
				end else if (rd_cnt[b] != RD_W'(RD_SAT)) begin
					rd_cnt[b] <= rd_cnt[b] + 1'b1;
				end
				if (sel_cmd == write_cmd && sel_bid == b) begin
					wr_cnt[b] <= '0;
				end else if (wr_cnt[b] != WR_W'(WR_SAT)) begin
					wr_cnt[b] <= wr_cnt[b] + 1'b1;
				end
			end
			for (int g = 0; g < `DDR_BG_NUM; g++) begin
				if (sel_cmd == activate && slot_bg[sel_slot] == g) begin
					bg_act_cnt[g] <= '0;
				end else if (bg_act_cnt[g] != RRD_W'(RRD_SAT)) begin
					bg_act_cnt[g] <= bg_act_cnt[g] + 1'b1;
				end
			end
			if (sel_cmd == read_cmd) begin
				g_rd_cnt <= '0;
			end else if (g_rd_cnt != GRD_W'(GRD_SAT)) begin
				g_rd_cnt <= g_rd_cnt + 1'b1;
			end
			if (sel_cmd == write_cmd) begin
				g_wr_cnt <= '0;
			end else if (g_wr_cnt != GWR_W'(GWR_SAT)) begin
				g_wr_cnt <= g_wr_cnt + 1'b1;
			end
			if (issue_valid) begin
				last_col <= slot_type[sel_slot];
			end
			if (sel_valid) begin
				rr_ptr <= sel_slot + 1'b1;  // next search starts after winner
			end
			cmd <= sel_cmd;
		end
	end

	// open row and cmd address, payload only
	always_ff @(posedge clk) begin
		if (sel_cmd == activate) begin
			open_row[sel_bid] <= slot_row[sel_slot];
		end
		if (sel_valid) begin
			cmd_bg   <= slot_bg[sel_slot];
			cmd_bank <= slot_bank[sel_slot];
			cmd_row  <= slot_row[sel_slot];
			cmd_col  <= slot_col_of_issue;
		end
	end

endmodule

`default_nettype wire

//--- hw/ddr_sched_top.sv
`timescale 1ns/1ps
`include "ddr_consts.svh"
`default_nettype none

module ddr_sched_top
	import ddr_cmd_pkg::*, ddr_addr_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,  // sync, high = reset

	// host request, credit flow control
	input  logic        req_valid,
	input  acc_type_t   req_type,
	input  logic [31:0] req_addr,
	output logic        credit_return,

	// dram command
	output dram_cmd_t   cmd,
	output bg_t         cmd_bg,
	output bank_t       cmd_bank,
	output row_t        cmd_row,
	output col_t        cmd_col
);

	// intake to slots
	logic      slot_wr;
	acc_type_t wr_type;
	bg_t       wr_bg;
	bank_t     wr_bank;
	row_t      wr_row;
	col_t      wr_col;

	// slots to controller and back
	slot_state_t [`DDR_NUM_SLOTS-1:0] slot_state;
	acc_type_t   [`DDR_NUM_SLOTS-1:0] slot_type;
	bg_t         [`DDR_NUM_SLOTS-1:0] slot_bg;
	bank_t       [`DDR_NUM_SLOTS-1:0] slot_bank;
	row_t        [`DDR_NUM_SLOTS-1:0] slot_row;
	col_t                             slot_col_of_issue;
	logic                             issue_valid;
	logic [`DDR_SLOT_W-1:0]           issue_slot;

	req_intake u_intake (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_type  (req_type),
		.req_addr  (req_addr),
		.slot_wr   (slot_wr),
		.wr_type   (wr_type),
		.wr_bg     (wr_bg),
		.wr_bank   (wr_bank),
		.wr_row    (wr_row),
		.wr_col    (wr_col)
	);

	req_slots u_slots (
		.clk               (clk),
		.rst_n             (rst_n),
		.slot_wr           (slot_wr),
		.wr_type           (wr_type),
		.wr_bg             (wr_bg),
		.wr_bank           (wr_bank),
		.wr_row            (wr_row),
		.wr_col            (wr_col),
		.issue_valid       (issue_valid),
		.issue_slot        (issue_slot),
		.slot_state        (slot_state),
		.slot_type         (slot_type),
		.slot_bg           (slot_bg),
		.slot_bank         (slot_bank),
		.slot_row          (slot_row),
		.slot_col_of_issue (slot_col_of_issue),
		.credit_return     (credit_return)
	);

	timing_controller u_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.slot_state        (slot_state),
		.slot_type         (slot_type),
		.slot_bg           (slot_bg),
		.slot_bank         (slot_bank),
		.slot_row          (slot_row),
		.slot_col_of_issue (slot_col_of_issue),
		.issue_valid       (issue_valid),
		.issue_slot        (issue_slot),
		.cmd               (cmd),
		.cmd_bg            (cmd_bg),
		.cmd_bank          (cmd_bank),
		.cmd_row           (cmd_row),
		.cmd_col           (cmd_col)
	);

endmodule

`default_nettype wire

//--- sim/tb_ddr_sched.sv
`timescale 1ns/1ps
`include "ddr_consts.svh"
`default_nettype none

module tb_ddr_sched
	import ddr_cmd_pkg::*, ddr_addr_pkg::*;
();

	localparam int REQ_COUNT   = 200;
	localparam int WAIT_LIMIT  = 4000;  // cycles per wait loop
	localparam int REQ_TIMEOUT = 2000;  // send to rd/wr on cmd

	typedef struct packed {
		acc_type_t   kind;
		logic [31:0] addr;
		int          sent;  // cycle the request was seen
	} host_req_t;

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	acc_type_t   req_type;
	logic [31:0] req_addr;
	logic        credit_return;
	dram_cmd_t   cmd;
	bg_t         cmd_bg;
	bank_t       cmd_bank;
	row_t        cmd_row;
	col_t        cmd_col;

	int        cyc;                      // cycles since start
	int        credits;                  // host-side credit count
	host_req_t pending[$];               // sent but not yet on cmd
	logic      row_open_m[`DDR_BANKS];   // bank model built from cmd
	row_t      open_row_m[`DDR_BANKS];
	int        last_act[`DDR_BANKS];
	int        last_pre[`DDR_BANKS];
	int        last_rd[`DDR_BANKS];
	int        last_wr[`DDR_BANKS];
	int        last_act_g[`DDR_BG_NUM];
	int        last_col_rd;              // any bank
	int        last_col_wr;

	ddr_sched_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_type      (req_type),
		.req_addr      (req_addr),
		.credit_return (credit_return),
		.cmd           (cmd),
		.cmd_bg        (cmd_bg),
		.cmd_bank      (cmd_bank),
		.cmd_row       (cmd_row),
		.cmd_col       (cmd_col)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_gap(input string rule, input int since, input int need);
		assert (cyc - since >= need) else
			stop_with_error($sformatf("%s gap too short: %0d cycles, need %0d",
				rule, cyc - since, need));
	endtask

	// same kind and same decoded address as the command on the bus
	function automatic bit request_matches(input host_req_t r);
		return ((r.kind == rd) == (cmd == read_cmd)) &&
		       (r.addr[`DDR_BG_MSB:`DDR_BG_LSB] == cmd_bg) &&
		       (r.addr[`DDR_BANK_MSB:`DDR_BANK_LSB] == cmd_bank) &&
		       (r.addr[`DDR_ROW_MSB:`DDR_ROW_LSB] == cmd_row) &&
		       (r.addr[`DDR_COL_MSB:`DDR_COL_LSB] == cmd_col);
	endfunction

	assert property (@(posedge clk) rst_n |=> (cmd == none && !credit_return))
		else stop_with_error($sformatf("ERR cmd exp=%h got=%h, credit_return exp=0 got=%h",
			none, $sampled(cmd), $sampled(credit_return)));
	assert property (@(posedge clk) disable iff (rst_n)
		credit_return == (cmd == read_cmd || cmd == write_cmd))
		else stop_with_error($sformatf("ERR credit_return exp=%h got=%h",
			$sampled(cmd == read_cmd || cmd == write_cmd), $sampled(credit_return)));
	assert property (@(posedge clk) credits <= `DDR_NUM_SLOTS)
		else stop_with_error($sformatf("ERR credits exp<=%h got=%h",
			`DDR_NUM_SLOTS, $sampled(credits)));

	// bank model and rule checks from pre-edge values
	always @(posedge clk) begin
		int b;
		int hit;
		b   = int'({cmd_bg, cmd_bank});
		hit = -1;
		if (!rst_n) begin
			credits <= credits - int'(req_valid) + int'(credit_return);
			case (cmd)
				activate: begin
					assert (!row_open_m[b]) else
						stop_with_error($sformatf("activate to open bank %h", b));
					check_gap("act to act, same bank", last_act[b], `DDR_T_RC);
					check_gap("pre to act", last_pre[b], `DDR_T_RP);
					check_gap("act to act, same group", last_act_g[cmd_bg], `DDR_T_RRD);
					row_open_m[b]      <= 1'b1;
					open_row_m[b]      <= cmd_row;
					last_act[b]        <= cyc;
					last_act_g[cmd_bg] <= cyc;
				end
				precharge: begin
					assert (row_open_m[b]) else
						stop_with_error($sformatf("precharge to closed bank %h", b));
					check_gap("act to pre", last_act[b], `DDR_T_RAS);
					check_gap("rd to pre", last_rd[b], `DDR_T_RTP);
					check_gap("wr to pre", last_wr[b], `DDR_T_WTP);
					row_open_m[b] <= 1'b0;
					last_pre[b]   <= cyc;
				end
				read_cmd, write_cmd: begin
					assert (row_open_m[b]) else
						stop_with_error($sformatf("column command to closed bank %h", b));
					assert (open_row_m[b] == cmd_row) else
						stop_with_error($sformatf("ERR cmd_row exp=%h got=%h",
							open_row_m[b], cmd_row));
					check_gap("act to column", last_act[b], `DDR_T_RCD);
					if (cmd == read_cmd) begin
						check_gap("rd to rd", last_col_rd, `DDR_T_CCD);
						check_gap("wr to rd", last_col_wr, `DDR_T_WTR);
						last_rd[b]  <= cyc;
						last_col_rd <= cyc;
					end else begin
						check_gap("wr to wr", last_col_wr, `DDR_T_CCD);
						check_gap("rd to wr", last_col_rd, `DDR_T_RTW);
						last_wr[b]  <= cyc;
						last_col_wr <= cyc;
					end
					for (int i = 0; i < pending.size(); i++) begin
						if (hit < 0 && request_matches(pending[i])) hit = i;
					end
					assert (hit >= 0) else
						stop_with_error($sformatf("no request for %s at bg %h bank %h row %h col %h",
							cmd.name(), cmd_bg, cmd_bank, cmd_row, cmd_col));
					pending.delete(hit);
				end
				default: ;
			endcase
			if (req_valid) pending.push_back({req_type, req_addr, cyc});
			assert (pending.size() == 0 || cyc - pending[0].sent < REQ_TIMEOUT) else
				stop_with_error($sformatf("request timed out: addr %h sent at cycle %0d",
					pending[0].addr, pending[0].sent));
		end
		cyc <= cyc + 1;
	end

	initial begin
		int n;
		int gap;
		int waited;
		logic [31:0] a;
		void'($urandom(32'h2c32_bdf0));
		cyc = 0;
		credits = `DDR_NUM_SLOTS;
		last_col_rd = -1000;  // far past so every rule is met
		last_col_wr = -1000;
		for (int i = 0; i < `DDR_BANKS; i++) begin
			row_open_m[i] = 1'b0;
			open_row_m[i] = '0;
			last_act[i] = -1000;
			last_pre[i] = -1000;
			last_rd[i] = -1000;
			last_wr[i] = -1000;
		end
		for (int g = 0; g < `DDR_BG_NUM; g++) last_act_g[g] = -1000;
		rst_n = 1'b1;
		req_valid = 1'b0;
		req_type = rd;
		req_addr = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b0;
		n = 0;
		gap = 0;
		waited = 0;
		while (n < REQ_COUNT) begin
			@(posedge clk);
			if (gap == 0 && credits - int'(req_valid) + int'(credit_return) > 0) begin
				a = $urandom;
				a[`DDR_BANK_MSB:`DDR_BANK_LSB] = 2'($urandom_range(0, 1));  // few banks
				a[`DDR_ROW_MSB:`DDR_ROW_LSB] = 16'($urandom_range(0, 2));   // hits and conflicts
				req_valid <= 1'b1;
				req_type  <= acc_type_t'($urandom_range(0, 1));
				req_addr  <= a;
				n++;
				gap = (n < `DDR_NUM_SLOTS) ? 0 : $urandom_range(0, 2);  // first ones back to back
				waited = 0;
			end else begin
				req_valid <= 1'b0;
				if (gap > 0) gap--;
				waited++;
				assert (waited < WAIT_LIMIT) else
					stop_with_error("timeout waiting for a credit to come back");
			end
		end
		@(posedge clk);
		req_valid <= 1'b0;
		waited = 0;
		while ((pending.size() != 0 || credits != `DDR_NUM_SLOTS) && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending.size() == 0 && credits == `DDR_NUM_SLOTS) begin
			$display("Everything OK");
			$finish;
		end else begin
			stop_with_error("timeout waiting for outstanding requests and credits");
		end
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/ddr_cmd_pkg.sv
hw/ddr_addr_pkg.sv
hw/req_intake.sv
hw/req_slots.sv
hw/timing_controller.sv
hw/ddr_sched_top.sv
sim/tb_ddr_sched.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_sched \
		-f list.f -o sim_ddr_sched
	./obj_dir/sim_ddr_sched | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
